// File: src.f
hw/prefetch_pkg.sv
hw/block_counter.sv
hw/prefetch_fsm.sv
hw/block_reader.sv
hw/word_fifo.sv
hw/block_writer.sv
hw/prefetch_top.sv
bench/bench_mem.sv
bench/prefetch_tb.sv

// File: bench/prefetch_tb.sv
`timescale 1ns/100ps
module prefetch_tb;

   // Run length in whole blocks.
   localparam int BLOCKS    = (prefetch_pkg::FETCH_COUNT + prefetch_pkg::BLOCK_SIZE - 1)
                              / prefetch_pkg::BLOCK_SIZE;
   localparam int RUN_WORDS = BLOCKS * prefetch_pkg::BLOCK_SIZE;
   localparam int MEM_WORDS = 2 ** prefetch_pkg::ADDR_BITS;
   localparam int WINDOW    = 2 ** prefetch_pkg::BLOCK_BITS;
   // Read index that faults is block 2 word 3.
   localparam int ERR_INDEX = 2 * prefetch_pkg::BLOCK_SIZE + 3;
   localparam int TIMEOUT   = 4000;

   logic                               clk_i;
   logic                               rst_i;
   logic                               begin_run;
   logic                               ready;
   logic                               fault;
   prefetch_pkg::wb_req_t              src_req;
   prefetch_pkg::wb_rsp_t              src_rsp;
   prefetch_pkg::wb_req_t              dst_req;
   prefetch_pkg::wb_rsp_t              dst_rsp;
   logic                               src_wait;
   logic                               dst_wait;
   logic                               err_en;
   logic [prefetch_pkg::ADDR_BITS-1:0] err_adr;

   int                                 error_count;
   int                                 test_errors;
   int                                 test_num;
   string                              test_name;
   int                                 ready_count;
   bit                                 timed_out;
   // Source addresses in the order the source memory answered them.
   logic [prefetch_pkg::ADDR_BITS-1:0] src_log [$];

   always #50 clk_i = ~clk_i;

   prefetch_top DUT (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .begin_i  (begin_run),
      .ready_o  (ready),
      .fault_o  (fault),
      .src_req_o(src_req),
      .src_rsp_i(src_rsp),
      .dst_req_o(dst_req),
      .dst_rsp_i(dst_rsp)
   );

   bench_mem src_mem (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wait_en_i(src_wait),
      .err_en_i (err_en),
      .err_adr_i(err_adr),
      .req_i    (src_req),
      .rsp_o    (src_rsp)
   );

   bench_mem dst_mem (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wait_en_i(dst_wait),
      .err_en_i (1'b0),
      .err_adr_i('0),
      .req_i    (dst_req),
      .rsp_o    (dst_rsp)
   );

   // ----------------------------------------------------------
   // Reference model.
   // ----------------------------------------------------------
   // Source address of run word i.
   function automatic logic [prefetch_pkg::ADDR_BITS-1:0] source_addr(input int i);
      return prefetch_pkg::ADDR_BITS'((i / prefetch_pkg::BLOCK_SIZE) * WINDOW
                                      + (i % prefetch_pkg::BLOCK_SIZE));
   endfunction

   function automatic logic [31:0] source_word(input int a);
      return (32'(a) * 32'h0101_0101) ^ 32'hA5A5_A5A5;
   endfunction

   // Expected destination word at index i.
   function automatic logic [31:0] expected_word(input int i);
      return source_word(int'(source_addr(i)));
   endfunction

   // Marks words the DUT never wrote.
   function automatic logic [31:0] dest_fill(input int a);
      return 32'h5A00_0000 | (32'(a) * 32'h0000_0101);
   endfunction

   task automatic fill_memories();
      for (int a = 0; a < MEM_WORDS; a++) begin
         src_mem.mem[a] = source_word(a);
         dst_mem.mem[a] = dest_fill(a);
      end
   endtask

   // Source reads and ready pulses are sampled mid cycle.
   always @(negedge clk_i) begin
      if (src_req.stb && (src_rsp.ack || src_rsp.err)) begin
         src_log.push_back(src_req.adr);
      end
      if (ready) begin
         ready_count++;
      end
   end

   // ----------------------------------------------------------
   // Test steps.
   // ----------------------------------------------------------
   task automatic test_start(input string name);
      test_num++;
      test_name   = name;
      test_errors = error_count;
   endtask

   task automatic test_finish();
      $display("test %0d %s: %0d errors", test_num, test_name, error_count - test_errors);
   endtask

   // Begin strobe and a bounded wait for ready.
   task automatic run_once(input logic expect_fault);
      int cycles;
      src_log.delete();
      ready_count = 0;
      begin_run   = 1'b1;
      @(negedge clk_i);
      begin_run = 1'b0;
      if (fault !== 1'b0) begin
         $display("FAILED at %0t: fault_o not cleared by begin", $time);
         error_count++;
      end
      cycles = 0;
      while (!ready && cycles < TIMEOUT) begin
         @(negedge clk_i);
         cycles++;
      end
      if (!ready) begin
         $display("test %0d (%s) timed out waiting for ready_o", test_num, test_name);
         timed_out = 1'b1;
      end else begin
         if (fault !== expect_fault) begin
            $display("FAILED at %0t: fault_o = %b, expected %b", $time, fault, expect_fault);
            error_count++;
         end
         // Idle a little so a second pulse would show.
         repeat (4) @(negedge clk_i);
         if (ready_count != 1) begin
            $display("FAILED at %0t: %0d ready pulses, expected 1", $time, ready_count);
            error_count++;
         end
         // The flag stays until the next begin.
         if (fault !== expect_fault) begin
            $display("FAILED at %0t: fault_o = %b after ready, expected %b held",
                     $time, fault, expect_fault);
            error_count++;
         end
      end
   endtask

   // The first good_words hold the reference and the rest keep the fill.
   task automatic check_dest(input int good_words);
      logic [31:0] expected;
      for (int a = 0; a < MEM_WORDS; a++) begin
         expected = (a < good_words) ? expected_word(a) : dest_fill(a);
         if (dst_mem.mem[a] !== expected) begin
            $display("FAILED at %0t: dst[%0d] = %h, expected %h",
                     $time, a, dst_mem.mem[a], expected);
            error_count++;
         end
      end
   endtask

   task automatic check_source_log(input int reads);
      if (src_log.size() != reads) begin
         $display("FAILED at %0t: %0d source reads, expected %0d", $time, src_log.size(), reads);
         error_count++;
      end
      for (int n = 0; n < src_log.size(); n++) begin
         if ((int'(src_log[n]) % WINDOW) >= prefetch_pkg::BLOCK_SIZE) begin
            $display("FAILED at %0t: read %0d at %h is outside its block", $time, n, src_log[n]);
            error_count++;
         end
         if (src_log[n] !== source_addr(n)) begin
            $display("FAILED at %0t: read %0d at %h, expected %h",
                     $time, n, src_log[n], source_addr(n));
            error_count++;
         end
      end
   endtask

   // ----------------------------------------------------------
   // Main sequence.
   // ----------------------------------------------------------
   initial begin
      clk_i       = 1'b0;
      rst_i       = 1'b1;
      begin_run   = 1'b0;
      src_wait    = 1'b0;
      dst_wait    = 1'b0;
      err_en      = 1'b0;
      err_adr     = source_addr(ERR_INDEX);
      error_count = 0;
      test_num    = 0;
      ready_count = 0;
      timed_out   = 1'b0;
      fill_memories();
      repeat (3) @(negedge clk_i);
      rst_i = 1'b0;

      test_start("reset state");
      if (src_req.cyc !== 1'b0 || dst_req.cyc !== 1'b0 || ready !== 1'b0 || fault !== 1'b0) begin
         $display("FAILED at %0t: outputs not idle after reset", $time);
         error_count++;
      end
      test_finish();

      test_start("full run without wait states");
      run_once(1'b0);
      check_dest(RUN_WORDS);
      test_finish();

      if (!timed_out) begin
         test_start("random wait states");
         fill_memories();
         src_wait = 1'b1;
         dst_wait = 1'b1;
         run_once(1'b0);
         check_dest(RUN_WORDS);
         test_finish();
      end

      if (!timed_out) begin
         // Uses the reads logged by the previous run.
         test_start("source address pattern");
         check_source_log(RUN_WORDS);
         test_finish();
      end

      if (!timed_out) begin
         test_start("error abort");
         fill_memories();
         err_en = 1'b1;
         run_once(1'b1);
         check_source_log(ERR_INDEX + 1);
         check_dest(ERR_INDEX);
         test_finish();
      end

      if (!timed_out) begin
         test_start("restart after fault");
         fill_memories();
         err_en   = 1'b0;
         src_wait = 1'b0;
         dst_wait = 1'b0;
         run_once(1'b0);
         check_dest(RUN_WORDS);
         test_finish();
      end

      $display("tests run %0d, errors %0d, timeout %0d", test_num, error_count, timed_out);
      if (timed_out || error_count != 0) begin
         $display(">>> FAIL");
      end else begin
         $display(">>> PASS");
      end
      $finish;
   end

endmodule

// File: bench/bench_mem.sv
`timescale 1ns/100ps
module bench_mem (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  logic                               wait_en_i,
   input  logic                               err_en_i,
   input  logic [prefetch_pkg::ADDR_BITS-1:0] err_adr_i,
   input  prefetch_pkg::wb_req_t              req_i,
   output prefetch_pkg::wb_rsp_t              rsp_o
);

   // 16-bit maximal length polynomial, shifted right.
   localparam logic [15:0] LFSR_SEED = 16'd10086;
   localparam logic [15:0] LFSR_TAPS = 16'hB400;

   logic [prefetch_pkg::WIDTH-1:0] mem [2 ** prefetch_pkg::ADDR_BITS];
   logic [15:0]                    lfsr_q;
   logic                           ack_q;
   logic                           err_q;
   logic                           wat_q;
   logic [prefetch_pkg::WIDTH-1:0] dat_q;

   // One Galois step, the bit taken is state[0].
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      if (state[0]) begin
         return (state >> 1) ^ LFSR_TAPS;
      end
      return state >> 1;
   endfunction

   // ----------------------------------------------------------
   // Slave response, never in the cycle that stb first shows.
   // ----------------------------------------------------------
   always @(posedge clk_i) begin
      if (rst_i) begin
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
         wat_q  <= 1'b0;
         lfsr_q <= LFSR_SEED;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         wat_q <= 1'b0;
         // Skip the cycle where the last response is still out.
         if (req_i.cyc && req_i.stb && !ack_q && !err_q) begin
            if (wait_en_i) begin
               lfsr_q <= lfsr_step(lfsr_q);
            end
            if (wait_en_i && lfsr_q[0]) begin
               // Stall one more cycle.
               wat_q <= 1'b1;
            end else if (err_en_i && !req_i.we && req_i.adr == err_adr_i) begin
               err_q <= 1'b1;
            end else begin
               ack_q <= 1'b1;
               if (req_i.we) begin
                  mem[req_i.adr] <= req_i.dat;
               end else begin
                  dat_q <= mem[req_i.adr];
               end
            end
         end
      end
   end

   assign rsp_o = '{ack: ack_q, wat: wat_q, err: err_q, dat: dat_q};

endmodule

// File: hw/prefetch_top.sv
`timescale 1ns/100ps
module prefetch_top (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  begin_i,
   output logic                  ready_o,
   output logic                  fault_o,
   output prefetch_pkg::wb_req_t src_req_o,
   input  prefetch_pkg::wb_rsp_t src_rsp_i,
   output prefetch_pkg::wb_req_t dst_req_o,
   input  prefetch_pkg::wb_rsp_t dst_rsp_i
);

   logic [prefetch_pkg::ADDR_BITS-1:0] src_adr;
   logic                               block_last;
   logic                               run_last;
   logic                               fetch_en;
   logic                               word_rd;
   logic [prefetch_pkg::WIDTH-1:0]     word;
   logic                               rd_fault;
   logic                               fifo_full;
   logic                               fifo_empty;
   logic                               pop;
   logic [prefetch_pkg::WIDTH-1:0]     head_word;
   logic                               writer_busy;

   // ----------------------------------------------------------
   // Source side.
   // ----------------------------------------------------------
   block_counter u_counter (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .begin_i     (begin_i),
      .word_rd_i   (word_rd),
      .src_adr_o   (src_adr),
      .block_last_o(block_last),
      .run_last_o  (run_last)
   );

   prefetch_fsm u_fsm (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .begin_i      (begin_i),
      .block_last_i (block_last),
      .run_last_i   (run_last),
      .word_rd_i    (word_rd),
      .fault_i      (rd_fault),
      .fifo_empty_i (fifo_empty),
      .writer_busy_i(writer_busy),
      .fetch_en_o   (fetch_en),
      .ready_o      (ready_o),
      .fault_o      (fault_o)
   );

   block_reader u_reader (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .fetch_en_i (fetch_en),
      .fifo_full_i(fifo_full),
      .src_adr_i  (src_adr),
      .src_req_o  (src_req_o),
      .src_rsp_i  (src_rsp_i),
      .word_rd_o  (word_rd),
      .word_o     (word),
      .fault_o    (rd_fault)
   );

   // ----------------------------------------------------------
   // Staging and destination side.
   // ----------------------------------------------------------
   word_fifo u_fifo (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .push_i     (word_rd),
      .push_data_i(word),
      .pop_i      (pop),
      .pop_data_o (head_word),
      .empty_o    (fifo_empty),
      .full_o     (fifo_full)
   );

   block_writer u_writer (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .begin_i     (begin_i),
      .fifo_empty_i(fifo_empty),
      .fifo_data_i (head_word),
      .pop_o       (pop),
      .dst_req_o   (dst_req_o),
      .dst_rsp_i   (dst_rsp_i),
      .busy_o      (writer_busy)
   );

endmodule

// File: hw/block_writer.sv
`timescale 1ns/100ps
module block_writer (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           begin_i,
   input  logic                           fifo_empty_i,
   input  logic [prefetch_pkg::WIDTH-1:0] fifo_data_i,
   output logic                           pop_o,
   output prefetch_pkg::wb_req_t          dst_req_o,
   input  prefetch_pkg::wb_rsp_t          dst_rsp_i,
   output logic                           busy_o
);

   logic                               cyc_q;
   logic [prefetch_pkg::ADDR_BITS-1:0] adr_q;
   logic [prefetch_pkg::WIDTH-1:0]     dat_q;
   // Next destination address, sequential over the run.
   logic [prefetch_pkg::ADDR_BITS-1:0] dst_adr_q;
   logic                               done;
   logic                               load;

   assign done = cyc_q & dst_rsp_i.ack;
   // Take the head word once the bus is free.
   assign load = ~cyc_q & ~fifo_empty_i;

   // ----------------------------------------------------------
   // Bus control and address counter.
   // ----------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cyc_q     <= 1'b0;
         dst_adr_q <= '0;
      end else begin
         if (done) begin
            cyc_q <= 1'b0;
         end else if (load) begin
            cyc_q <= 1'b1;
         end
         if (begin_i) begin
            dst_adr_q <= '0;
         end else if (done) begin
            dst_adr_q <= dst_adr_q + 1'b1;
         end
      end
   end

   // Write payload, fixed from load until ack.
   always_ff @(posedge clk_i) begin
      if (load) begin
         adr_q <= dst_adr_q;
         dat_q <= fifo_data_i;
      end
   end

   always_comb begin
      dst_req_o     = '0;
      dst_req_o.cyc = cyc_q;
      dst_req_o.stb = cyc_q;
      dst_req_o.we  = cyc_q;
      dst_req_o.adr = adr_q;
      dst_req_o.dat = dat_q;
   end

   // The word leaves the FIFO only when the slave has taken it.
   assign pop_o  = done;
   // Idle in the ack cycle, so the FSM can finish one cycle later.
   assign busy_o = cyc_q & ~dst_rsp_i.ack;

endmodule

// File: hw/word_fifo.sv
`timescale 1ns/100ps
module word_fifo (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           push_i,
   input  logic [prefetch_pkg::WIDTH-1:0] push_data_i,
   input  logic                           pop_i,
   output logic [prefetch_pkg::WIDTH-1:0] pop_data_o,
   output logic                           empty_o,
   output logic                           full_o
);

   logic [prefetch_pkg::WIDTH-1:0]       mem [prefetch_pkg::FIFO_DEPTH];
   logic [prefetch_pkg::FIFO_PTR_BITS-1:0] wr_ptr_q;
   logic [prefetch_pkg::FIFO_PTR_BITS-1:0] rd_ptr_q;
   // One bit wider than the pointers so full can be told from empty.
   logic [prefetch_pkg::FIFO_PTR_BITS:0]   count_q;
   logic                                   do_push;
   logic                                   do_pop;

   assign full_o  = (count_q == (prefetch_pkg::FIFO_PTR_BITS + 1)'(prefetch_pkg::FIFO_DEPTH));
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & (count_q != '0);

   // Empty as of the next edge, so a final pop counts as drained.
   assign empty_o = (count_q == '0) | ((count_q == 1) & do_pop & ~push_i);

   // ----------------------------------------------------------
   // Storage and pointers.
   // ----------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         // Pointers wrap on their own, depth is a power of two.
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         if (do_push && !do_pop) begin
            count_q <= count_q + 1'b1;
         end else if (do_pop && !do_push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // Head of the queue.
   assign pop_data_o = mem[rd_ptr_q];

endmodule

// File: hw/block_reader.sv
`timescale 1ns/100ps
module block_reader (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  logic                               fetch_en_i,
   input  logic                               fifo_full_i,
   input  logic [prefetch_pkg::ADDR_BITS-1:0] src_adr_i,
   output prefetch_pkg::wb_req_t              src_req_o,
   input  prefetch_pkg::wb_rsp_t              src_rsp_i,
   output logic                               word_rd_o,
   output logic [prefetch_pkg::WIDTH-1:0]     word_o,
   output logic                               fault_o
);

   // Set while a read waits for its ack.
   logic                               pending_q;
   // Address of the outstanding read.
   logic [prefetch_pkg::ADDR_BITS-1:0] adr_q;
   logic                               req_on;
   logic                               ended;

   // ----------------------------------------------------------
   // Request generation.
   // ----------------------------------------------------------
   // A new read needs the run enabled and room in the FIFO.
   // Once issued it stays up until ack or err.
   assign req_on = pending_q | (fetch_en_i & ~fifo_full_i);
   assign ended  = src_rsp_i.ack | src_rsp_i.err;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pending_q <= 1'b0;
      end else begin
         // Wait states leave this set.
         pending_q <= req_on & ~ended;
      end
   end

   // Latch the address when a read is first issued.
   always_ff @(posedge clk_i) begin
      if (!pending_q) begin
         adr_q <= src_adr_i;
      end
   end

   always_comb begin
      src_req_o     = '0;
      src_req_o.cyc = req_on;
      src_req_o.stb = req_on;
      // Source port only reads.
      src_req_o.we  = 1'b0;
      src_req_o.adr = pending_q ? adr_q : src_adr_i;
   end

   // ----------------------------------------------------------
   // Response handling.
   // ----------------------------------------------------------
   // One pulse per ack, which pushes the word and steps the counter.
   assign word_rd_o = req_on & src_rsp_i.ack;
   assign word_o    = src_rsp_i.dat;
   // err ends the word with a fault, and nothing is pushed.
   assign fault_o   = req_on & src_rsp_i.err;

endmodule

// File: hw/prefetch_fsm.sv
`timescale 1ns/100ps
module prefetch_fsm (
   input  logic clk_i,
   input  logic rst_i,
   input  logic begin_i,
   input  logic block_last_i,
   input  logic run_last_i,
   input  logic word_rd_i,
   input  logic fault_i,
   input  logic fifo_empty_i,
   input  logic writer_busy_i,
   output logic fetch_en_o,
   output logic ready_o,
   output logic fault_o
);

   prefetch_pkg::run_state_t state_q;
   prefetch_pkg::run_state_t state_nxt;
   logic                     final_word;
   logic                     drained;
   logic                     fault_q;

   // Last ack of the last block in the run.
   assign final_word = word_rd_i & block_last_i & run_last_i;
   // Nothing left in the FIFO and no write in flight.
   assign drained    = fifo_empty_i & ~writer_busy_i;

   // ----------------------------------------------------------
   // Next state.
   // ----------------------------------------------------------
   always_comb begin
      state_nxt = state_q;
      case (state_q)
         prefetch_pkg::IDLE: begin
            if (begin_i) state_nxt = prefetch_pkg::FETCH;
         end
         prefetch_pkg::FETCH: begin
            // An error aborts the rest of the fetch.
            if (fault_i || final_word) state_nxt = prefetch_pkg::DRAIN;
         end
         prefetch_pkg::DRAIN: begin
            if (drained) state_nxt = prefetch_pkg::FINISH;
         end
         prefetch_pkg::FINISH: begin
            // Single cycle, a new begin here starts straight away.
            state_nxt = begin_i ? prefetch_pkg::FETCH : prefetch_pkg::IDLE;
         end
         default: state_nxt = prefetch_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= prefetch_pkg::IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   // Fault flag, held until the next run starts.
   always_ff @(posedge clk_i) begin
      if (rst_i || begin_i) begin
         fault_q <= 1'b0;
      end else if (fault_i) begin
         fault_q <= 1'b1;
      end
   end

   assign fetch_en_o = (state_q == prefetch_pkg::FETCH);
   assign ready_o    = (state_q == prefetch_pkg::FINISH);
   assign fault_o    = fault_q;

endmodule

// File: hw/block_counter.sv
`timescale 1ns/100ps
module block_counter (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  logic                                 begin_i,
   input  logic                                 word_rd_i,
   output logic [prefetch_pkg::ADDR_BITS-1:0]   src_adr_o,
   output logic                                 block_last_o,
   output logic                                 run_last_o
);

   // Block index goes in the upper address bits.
   logic [prefetch_pkg::BLOCK_IDX_BITS-1:0] block_q;
   // Word offset inside the current window.
   logic [prefetch_pkg::BLOCK_BITS-1:0]     word_q;
   logic [prefetch_pkg::BLOCK_BITS-1:0]     word_nxt;
   // Word count at which the current block ends.
   logic [prefetch_pkg::RUN_BITS-1:0]       blk_end_q;
   logic [prefetch_pkg::RUN_BITS-1:0]       blk_end_nxt;
   logic                                    block_last_q;
   logic                                    run_last_q;

   assign word_nxt    = word_q + 1'b1;
   assign blk_end_nxt = blk_end_q + prefetch_pkg::RUN_BITS'(prefetch_pkg::BLOCK_SIZE);

   // ----------------------------------------------------------
   // Counters, with the end flags worked out one word ahead.
   // ----------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         block_q      <= '0;
         word_q       <= '0;
         blk_end_q    <= '0;
         block_last_q <= 1'b0;
         run_last_q   <= 1'b0;
      end else if (begin_i) begin
         block_q      <= '0;
         word_q       <= '0;
         blk_end_q    <= prefetch_pkg::RUN_BITS'(prefetch_pkg::BLOCK_SIZE);
         block_last_q <= (prefetch_pkg::BLOCK_SIZE == 1);
         run_last_q   <= (prefetch_pkg::BLOCK_SIZE >= prefetch_pkg::FETCH_COUNT);
      end else if (word_rd_i) begin
         if (block_last_q) begin
            // Jump to the start of the next window.
            block_q      <= block_q + 1'b1;
            word_q       <= '0;
            blk_end_q    <= blk_end_nxt;
            block_last_q <= (prefetch_pkg::BLOCK_SIZE == 1);
            run_last_q   <= (blk_end_nxt >= prefetch_pkg::FETCH_COUNT);
         end else begin
            word_q       <= word_nxt;
            block_last_q <= (word_nxt ==
                             prefetch_pkg::BLOCK_BITS'(prefetch_pkg::BLOCK_SIZE - 1));
         end
      end
   end

   assign src_adr_o    = {block_q, word_q};
   assign block_last_o = block_last_q;
   assign run_last_o   = run_last_q;

endmodule

// File: hw/prefetch_pkg.sv
package prefetch_pkg;

   // ----------------------------------------------------------
   // Sizes.
   // ----------------------------------------------------------
   // Data word width on both ports.
   localparam int WIDTH       = 32;
   // Address width on both ports.
   localparam int ADDR_BITS   = 8;
   // Each block sits in a 2^BLOCK_BITS-word source window.
   localparam int BLOCK_BITS  = 3;
   // Words fetched from each window.
   localparam int BLOCK_SIZE  = 6;
   // Minimum words per run, rounded up to whole blocks.
   localparam int FETCH_COUNT = 40;
   // Staging FIFO entries.
   localparam int FIFO_DEPTH  = 4;

   // Derived widths.
   localparam int BLOCK_IDX_BITS = ADDR_BITS - BLOCK_BITS;
   localparam int FIFO_PTR_BITS  = $clog2(FIFO_DEPTH);
   // Wide enough for a run's word total plus one block.
   localparam int RUN_BITS       = ADDR_BITS + 1;

   // ----------------------------------------------------------
   // Bus types.
   // ----------------------------------------------------------
   // Master to slave.
   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [ADDR_BITS-1:0] adr;
      logic [WIDTH-1:0]     dat;
   } wb_req_t;

   // Slave to master; wat stalls the request.
   typedef struct packed {
      logic             ack;
      logic             wat;
      logic             err;
      logic [WIDTH-1:0] dat;
   } wb_rsp_t;

   // Run control states.
   typedef enum logic [1:0] {
      IDLE,
      FETCH,
      DRAIN,
      FINISH
   } run_state_t;

endpackage
